/* project.f */
logic/softmax_pkg.sv
logic/softmax_ctrl.sv
logic/softmax_beat_counter.sv
logic/softmax_accum.sv
logic/softmax_divider.sv
logic/softmax_stream.sv
logic/softmax_top.sv
dv/softmax_checker.sv
dv/softmax_tb.sv

/* Makefile */
# Verilator flow for the softmax unit, the exit status of run is the test verdict
TOP := softmax_tb
OBJ := obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -Mdir $(OBJ) -f project.f

run: compile
	./$(OBJ)/V$(TOP)

clean:
	rm -rf $(OBJ)

/* dv/softmax_tb.sv */
// Each table row is sent once to accumulate and once to stream
// Expected beats are queued at acceptance and compared when prob_valid_o shows up
`timescale 1ns/100ps

module softmax_tb;

  localparam int NumDirected = 5;
  localparam int NumRandom   = 10;
  localparam int NumRows     = NumDirected + NumRandom;

  logic                     clk_i;
  logic                     rst_ni;
  logic                     start_i;
  softmax_pkg::seq_len_t    seq_len_i;
  logic                     score_valid_i;
  softmax_pkg::score_beat_t score_i;
  logic                     accept_o;
  logic                     prob_valid_o;
  logic                     done_o;
  softmax_pkg::prob_beat_t  prob_o;

  int           row_len [NumRows];
  bit           row_uniform [NumRows];
  bit           row_gaps [NumRows];
  logic [127:0] row_scores [NumRows];
  logic [32:0]  exp_q [$];
  logic [32:0]  exp_beat;
  int           done_count = 0;
  integer       seed;

  softmax_top u_dut (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .start_i      (start_i),
    .seq_len_i    (seq_len_i),
    .score_valid_i(score_valid_i),
    .score_i      (score_i),
    .accept_o     (accept_o),
    .prob_valid_o (prob_valid_o),
    .done_o       (done_o),
    .prob_o       (prob_o)
  );

  bind softmax_top softmax_checker u_checker (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .stream_en_i (stream_en),
    .accept_i    (accept_o),
    .prob_valid_i(prob_valid_o),
    .done_i      (done_o),
    .prob_i      (prob_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("=== FAIL ===");
    $fatal(1);
  endtask

  // Base-2 shift is d/32 plus bit 4 of d, at most 15
  function automatic int shift_of(input int d);
    int s;
    s = d / 32 + (d / 16) % 2;
    return (s > 15) ? 15 : s;
  endfunction

  function automatic int col_score(input logic [127:0] sc, input int c);
    return int'($signed(sc[c*8 +: 8]));
  endfunction

  function automatic logic [127:0] model_probs(input logic [127:0] sc, input int len);
    int mx;
    int sum;
    int recip;
    int bmx;
    int c;
    logic [127:0] p;
    mx  = 0;
    sum = 0;
    p   = '0;
    for (int b = 0; b < softmax_pkg::BeatsPerRow; b++) begin
      bmx = -129;
      for (int i = 0; i < softmax_pkg::NumLanes; i++) begin
        c = b * softmax_pkg::NumLanes + i;
        if (c < len && col_score(sc, c) > bmx) begin
          bmx = col_score(sc, c);
        end
      end
      // A fully masked beat leaves max and sum untouched
      if (bmx == -129) begin
        continue;
      end
      if (b == 0) begin
        mx = bmx;
      end else if (bmx > mx) begin
        sum = sum >> shift_of(bmx - mx);
        mx  = bmx;
      end
      for (int i = 0; i < softmax_pkg::NumLanes; i++) begin
        c = b * softmax_pkg::NumLanes + i;
        if (c < len) begin
          sum = sum + (256 >> shift_of(mx - col_score(sc, c)));
        end
      end
    end
    recip = softmax_pkg::RecipNumerator / sum;
    for (c = 0; c < len; c++) begin
      p[c*8 +: 8] = 8'(recip >> shift_of(mx - col_score(sc, c)));
    end
    return p;
  endfunction

  task automatic set_row(input int r, input int len, input bit uniform, input bit gaps,
                         input logic [127:0] sc);
    row_len[r]     = len;
    row_uniform[r] = uniform;
    row_gaps[r]    = gaps;
    row_scores[r]  = sc;
  endtask

  // Returns in the cycle before the edge that accepts the beat
  task automatic drive_beat(input softmax_pkg::score_beat_t beat);
    @(posedge clk_i);
    score_valid_i <= 1'b1;
    score_i       <= beat;
    @(negedge clk_i);
    while (!accept_o) begin
      @(negedge clk_i);
    end
  endtask

  task automatic idle_for(input int n);
    repeat (n) begin
      @(posedge clk_i);
      score_valid_i <= 1'b0;
    end
  endtask

  task automatic drive_stray(input int n);
    repeat (n) begin
      @(posedge clk_i);
      score_valid_i <= 1'b1;
      score_i       <= $random(seed);
      @(negedge clk_i);
      assert (!accept_o) else abort_run("A stray beat met accept_o high");
    end
  endtask

  task automatic run_row(input int r);
    logic [127:0] sc;
    logic [127:0] probs;
    sc = row_scores[r];
    if (row_uniform[r]) begin
      probs = {16{8'h08}};
    end else begin
      probs = model_probs(sc, row_len[r]);
    end
    if (row_gaps[r]) begin
      drive_stray(3);
    end
    @(posedge clk_i);
    start_i   <= 1'b1;
    seq_len_i <= softmax_pkg::seq_len_t'(row_len[r]);
    @(posedge clk_i);
    start_i       <= 1'b0;
    score_valid_i <= 1'b0;
    for (int b = 0; b < softmax_pkg::BeatsPerRow; b++) begin
      drive_beat(sc[b*32 +: 32]);
      if (row_gaps[r] && b < softmax_pkg::BeatsPerRow - 1) begin
        idle_for(2);
      end
    end
    if (row_gaps[r]) begin
      drive_stray(4);
    end
    for (int b = 0; b < softmax_pkg::BeatsPerRow; b++) begin
      drive_beat(sc[b*32 +: 32]);
      exp_q.push_back({b == softmax_pkg::BeatsPerRow - 1, probs[b*32 +: 32]});
      if (row_gaps[r] && b < softmax_pkg::BeatsPerRow - 1) begin
        idle_for(1);
      end
    end
    idle_for(2);
    @(negedge clk_i);
    assert (exp_q.size() == 0) else abort_run("Probability beats missing at the end of a row");
    assert (done_count == r + 1) else
      abort_run($sformatf("CHECK FAILED done_count got %h expected %h", done_count, r + 1));
  endtask

  always @(negedge clk_i) begin
    // Every done_o pulse counts, with or without prob_valid_o
    if (rst_ni && done_o) begin
      done_count++;
    end
    if (rst_ni && prob_valid_o) begin
      assert (exp_q.size() > 0) else abort_run("prob_valid_o rose with no stream beat pending");
      exp_beat = exp_q.pop_front();
      assert (prob_o == exp_beat[31:0]) else
        abort_run($sformatf("CHECK FAILED prob_o got %h expected %h", prob_o, exp_beat[31:0]));
      assert (done_o == exp_beat[32]) else
        abort_run($sformatf("CHECK FAILED done_o got %h expected %h", done_o, exp_beat[32]));
    end
  end

  initial begin
    repeat (8 + NumRows * 60) @(posedge clk_i);
    abort_run("Watchdog expired before all rows finished");
  end

  initial begin
    rst_ni        = 1'b0;
    start_i       = 1'b0;
    seq_len_i     = '0;
    score_valid_i = 1'b0;
    score_i       = '0;
    seed          = 92;
    set_row(0, 16, 1'b0, 1'b0, 128'h30e2057a_c410815f_2209b03c_66f1481d);
    // Masked columns hold large scores that must not count
    set_row(1, 7, 1'b0, 1'b0, 128'h7f7f7f7f_7f7f7f7f_7f900a25_f0401352);
    set_row(2, 16, 1'b0, 1'b0, 128'hf064e0d8_140a00ec_08f61204_e210fe0c);
    set_row(3, 16, 1'b1, 1'b0, {16{8'h25}});
    set_row(4, 11, 1'b0, 1'b1, 128'h5a5a5a5a_80337e19_0cad4820_f53e6107);
    for (int r = NumDirected; r < NumRows; r++) begin
      set_row(r, 1 + int'({$random(seed)} % 16), 1'b0, 1'b0,
              {$random(seed), $random(seed), $random(seed), $random(seed)});
    end
    repeat (8) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    assert ({accept_o, prob_valid_o, done_o} == 3'b000) else
      abort_run($sformatf("CHECK FAILED accept_o/prob_valid_o/done_o got %h expected 0",
                          {accept_o, prob_valid_o, done_o}));
    for (int r = 0; r < NumRows; r++) begin
      run_row(r);
    end
    $display("=== PASS ===");
    $finish;
  end

endmodule

/* dv/softmax_checker.sv */
// Bound checks on the output strobes of softmax_top
// A lane above 128 would read as a probability above 1.0
`timescale 1ns/100ps

module softmax_checker (
  input logic                    clk_i,
  input logic                    rst_ni,
  input logic                    stream_en_i,
  input logic                    accept_i,
  input logic                    prob_valid_i,
  input logic                    done_i,
  input softmax_pkg::prob_beat_t prob_i
);

  a_prob_after_beat: assert property (
    @(posedge clk_i) disable iff (!rst_ni) prob_valid_i |-> $past(stream_en_i)
  ) else $error("prob_valid_o without a stream beat accepted the cycle before");

  a_done_with_prob: assert property (
    @(posedge clk_i) disable iff (!rst_ni) done_i |-> prob_valid_i
  ) else $error("done_o without prob_valid_o");

  a_idle_after_done: assert property (
    @(posedge clk_i) disable iff (!rst_ni) done_i |=> !accept_i
  ) else $error("accept_o still high in the cycle after done_o");

  for (genvar i = 0; i < softmax_pkg::NumLanes; i++) begin : g_lane
    a_prob_bound: assert property (
      @(posedge clk_i) disable iff (!rst_ni) prob_i[i*8 +: 8] <= 8'd128
    ) else $error("prob_o lane above 128");
  end

endmodule

/* logic/softmax_top.sv */
// Row softmax unit: the row is sent twice, once to accumulate, once to stream
// seq_len_i is latched with start_i and must be 1 to RowLen
`timescale 1ns/100ps

module softmax_top (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     start_i,
  input  softmax_pkg::seq_len_t    seq_len_i,
  input  logic                     score_valid_i,
  input  softmax_pkg::score_beat_t score_i,
  output logic                     accept_o,
  output logic                     prob_valid_o,
  output logic                     done_o,
  output softmax_pkg::prob_beat_t  prob_o
);

  logic                   beat_en, row_clear, acc_en, div_start, stream_en;
  logic                   last_beat, acc_done, div_done;
  softmax_pkg::beat_idx_t beat_idx;
  softmax_pkg::score_t    row_max;
  softmax_pkg::sum_t      row_sum;
  softmax_pkg::recip_t    recip;
  softmax_pkg::seq_len_t  seq_len_q;

  // row_clear is start_i qualified by Idle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      seq_len_q <= '0;
    end else if (row_clear) begin
      seq_len_q <= seq_len_i;
    end
  end

  softmax_ctrl u_ctrl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .start_i      (start_i),
    .score_valid_i(score_valid_i),
    .last_beat_i  (last_beat),
    .acc_done_i   (acc_done),
    .div_done_i   (div_done),
    .beat_en_o    (beat_en),
    .row_clear_o  (row_clear),
    .acc_en_o     (acc_en),
    .div_start_o  (div_start),
    .stream_en_o  (stream_en),
    .accept_o     (accept_o)
  );

  softmax_beat_counter u_beat_counter (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .clear_i    (row_clear),
    .beat_en_i  (beat_en),
    .beat_idx_o (beat_idx),
    .last_beat_o(last_beat)
  );

  softmax_accum u_accum (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .clear_i    (row_clear),
    .acc_en_i   (acc_en),
    .last_beat_i(last_beat),
    .score_i    (score_i),
    .beat_idx_i (beat_idx),
    .seq_len_i  (seq_len_q),
    .acc_done_o (acc_done),
    .row_max_o  (row_max),
    .row_sum_o  (row_sum)
  );

  softmax_divider u_divider (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .start_i   (div_start),
    .divisor_i (row_sum),
    .done_o    (div_done),
    .quotient_o(recip)
  );

  softmax_stream u_stream (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .stream_en_i (stream_en),
    .score_i     (score_i),
    .beat_idx_i  (beat_idx),
    .seq_len_i   (seq_len_q),
    .row_max_i   (row_max),
    .recip_i     (recip),
    .last_beat_i (last_beat),
    .prob_valid_o(prob_valid_o),
    .done_o      (done_o),
    .prob_o      (prob_o)
  );

endmodule

/* logic/softmax_stream.sv */
// Output stage, one registered probability beat per accepted stream beat
// recip_i must stay below 256 so a shifted value fits one probability lane
`timescale 1ns/100ps

module softmax_stream (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     stream_en_i,
  input  softmax_pkg::score_beat_t score_i,
  input  softmax_pkg::beat_idx_t   beat_idx_i,
  input  softmax_pkg::seq_len_t    seq_len_i,
  input  softmax_pkg::score_t      row_max_i,
  input  softmax_pkg::recip_t      recip_i,
  input  logic                     last_beat_i,
  output logic                     prob_valid_o,
  output logic                     done_o,
  output softmax_pkg::prob_beat_t  prob_o
);

  localparam int ScoreW = $bits(softmax_pkg::score_t);
  localparam int ProbW  = $bits(softmax_pkg::prob_t);
  localparam int Lanes  = softmax_pkg::NumLanes;

  softmax_pkg::score_t     lane_score;
  softmax_pkg::shift_t     lane_shift;
  softmax_pkg::prob_beat_t prob_d, prob_q;
  logic                    prob_valid_q, done_q;

  always_comb begin
    prob_d = '0;
    for (int i = 0; i < Lanes; i++) begin
      lane_score = softmax_pkg::score_t'(score_i[i*ScoreW +: ScoreW]);
      lane_shift = softmax_pkg::exp_shift(row_max_i - lane_score);
      // Masked columns stay at zero
      if ((int'(beat_idx_i) * Lanes + i) < int'(seq_len_i)) begin
        prob_d[i*ProbW +: ProbW] = softmax_pkg::prob_t'(recip_i >> lane_shift);
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      prob_valid_q <= 1'b0;
      done_q       <= 1'b0;
      prob_q       <= '0;
    end else begin
      prob_valid_q <= stream_en_i;
      done_q       <= stream_en_i && last_beat_i;
      if (stream_en_i) begin
        prob_q <= prob_d;
      end
    end
  end

  assign prob_valid_o = prob_valid_q;
  assign done_o       = done_q;
  assign prob_o       = prob_q;

endmodule

/* logic/softmax_divider.sv */
// Restoring divider, RecipNumerator / divisor_i, one quotient bit per cycle
// done_o follows start_i by DivIters+1 cycles; divisor must be nonzero
`timescale 1ns/100ps

module softmax_divider (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                start_i,
  input  softmax_pkg::sum_t   divisor_i,
  output logic                done_o,
  output softmax_pkg::recip_t quotient_o
);

  localparam int CntW = $clog2(softmax_pkg::DivIters + 1);
  localparam int DivW = $bits(softmax_pkg::sum_t);
  localparam int NumW = $bits(softmax_pkg::recip_t);

  logic                busy_q, done_q;
  logic [CntW-1:0]     cnt_q;
  softmax_pkg::sum_t   divisor_q;
  softmax_pkg::recip_t num_q, quot_q;
  logic [DivW:0]       rem_q, rem_shift, rem_next;
  logic                take;

  always_comb begin
    rem_shift = {rem_q[DivW-1:0], num_q[NumW-1]};
    take      = rem_shift >= {1'b0, divisor_q};
    rem_next  = take ? (rem_shift - {1'b0, divisor_q}) : rem_shift;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
      cnt_q  <= '0;
    end else begin
      done_q <= 1'b0;
      if (start_i) begin
        busy_q <= 1'b1;
        cnt_q  <= CntW'(softmax_pkg::DivIters);
      end else if (busy_q) begin
        cnt_q <= cnt_q - 1'b1;
        if (cnt_q == CntW'(1)) begin
          busy_q <= 1'b0;
          done_q <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      divisor_q <= divisor_i;
      num_q     <= softmax_pkg::recip_t'(softmax_pkg::RecipNumerator);
      rem_q     <= '0;
      quot_q    <= '0;
    end else if (busy_q) begin
      num_q  <= num_q << 1;
      rem_q  <= rem_next;
      quot_q <= {quot_q[NumW-2:0], take};
    end
  end

  assign done_o     = done_q;
  assign quotient_o = quot_q;

endmodule

/* logic/softmax_accum.sv */
// Running row maximum and rescaled exponential sum, two pipeline stages
// Lanes at or beyond seq_len_i are masked; lane 0 of beat 0 is assumed valid
`timescale 1ns/100ps

module softmax_accum (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     clear_i,
  input  logic                     acc_en_i,
  input  logic                     last_beat_i,
  input  softmax_pkg::score_beat_t score_i,
  input  softmax_pkg::beat_idx_t   beat_idx_i,
  input  softmax_pkg::seq_len_t    seq_len_i,
  output logic                     acc_done_o,
  output softmax_pkg::score_t      row_max_o,
  output softmax_pkg::sum_t        row_sum_o
);

  localparam int ScoreW = $bits(softmax_pkg::score_t);
  localparam int Lanes  = softmax_pkg::NumLanes;
  localparam softmax_pkg::sum_t   ExpOne   = 16'd256;
  localparam softmax_pkg::score_t ScoreMin = 8'sh80;

  softmax_pkg::score_t      lane_score [Lanes];
  logic [Lanes-1:0]         lane_active;
  softmax_pkg::score_t      beat_max;
  softmax_pkg::score_t      max_d, max_q;
  logic                     first_q;

  softmax_pkg::score_beat_t s1_score_q;
  logic [Lanes-1:0]         s1_active_q;
  softmax_pkg::score_t      s1_prev_max_q;
  logic                     s1_valid_q, s1_last_q, s1_first_q;

  softmax_pkg::sum_t        sum_d, sum_q;
  logic                     acc_done_q;

  // Stage 1: mask lanes and fold the beat maximum into the running one
  always_comb begin
    beat_max = ScoreMin;
    for (int i = 0; i < Lanes; i++) begin
      lane_score[i]  = softmax_pkg::score_t'(score_i[i*ScoreW +: ScoreW]);
      lane_active[i] = (int'(beat_idx_i) * Lanes + i) < int'(seq_len_i);
      if (lane_active[i] && (lane_score[i] > beat_max)) begin
        beat_max = lane_score[i];
      end
    end
    max_d = (first_q || (beat_max > max_q)) ? beat_max : max_q;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      first_q    <= 1'b1;
      s1_valid_q <= 1'b0;
      max_q      <= ScoreMin;
    end else begin
      s1_valid_q <= acc_en_i;
      if (clear_i) begin
        first_q <= 1'b1;
      end else if (acc_en_i) begin
        first_q <= 1'b0;
        max_q   <= max_d;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (acc_en_i) begin
      s1_score_q    <= score_i;
      s1_active_q   <= lane_active;
      s1_prev_max_q <= max_q;
      s1_last_q     <= last_beat_i;
      s1_first_q    <= first_q;
    end
  end

  // Stage 2: max_q already holds this beat's new maximum here
  always_comb begin
    if (s1_first_q) begin
      sum_d = '0;
    end else begin
      sum_d = sum_q >> softmax_pkg::exp_shift(max_q - s1_prev_max_q);
    end
    for (int i = 0; i < Lanes; i++) begin
      if (s1_active_q[i]) begin
        sum_d = sum_d + (ExpOne >> softmax_pkg::exp_shift(max_q - s1_score_q[i*ScoreW +: ScoreW]));
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sum_q      <= '0;
      acc_done_q <= 1'b0;
    end else begin
      acc_done_q <= s1_valid_q && s1_last_q;
      if (s1_valid_q) begin
        sum_q <= sum_d;
      end
    end
  end

  assign acc_done_o = acc_done_q;
  assign row_max_o  = max_q;
  assign row_sum_o  = sum_q;

endmodule

/* logic/softmax_beat_counter.sv */
// Beat position within a row, wraps so both passes over the row share it
`timescale 1ns/100ps

module softmax_beat_counter (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   clear_i,
  input  logic                   beat_en_i,
  output softmax_pkg::beat_idx_t beat_idx_o,
  output logic                   last_beat_o
);

  localparam softmax_pkg::beat_idx_t LastIdx =
      softmax_pkg::beat_idx_t'(softmax_pkg::BeatsPerRow - 1);

  softmax_pkg::beat_idx_t idx_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      idx_q <= '0;
    end else if (clear_i) begin
      idx_q <= '0;
    end else if (beat_en_i) begin
      if (idx_q == LastIdx) begin
        idx_q <= '0;
      end else begin
        idx_q <= idx_q + 1'b1;
      end
    end
  end

  assign beat_idx_o  = idx_q;
  assign last_beat_o = (idx_q == LastIdx);

endmodule

/* logic/softmax_ctrl.sv */
// Phase controller: accumulate, divide, then stream the same row again
// start_i is only sampled in Idle; one row is in flight at a time
`timescale 1ns/100ps

module softmax_ctrl (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic start_i,
  input  logic score_valid_i,
  input  logic last_beat_i,
  input  logic acc_done_i,
  input  logic div_done_i,
  output logic beat_en_o,
  output logic row_clear_o,
  output logic acc_en_o,
  output logic div_start_o,
  output logic stream_en_o,
  output logic accept_o
);

  softmax_pkg::ctrl_state_e state_q, state_d;

  assign accept_o    = (state_q == softmax_pkg::StAccum) || (state_q == softmax_pkg::StStream);
  assign beat_en_o   = score_valid_i && accept_o;
  assign row_clear_o = (state_q == softmax_pkg::StIdle) && start_i;
  assign acc_en_o    = beat_en_o && (state_q == softmax_pkg::StAccum);
  assign stream_en_o = beat_en_o && (state_q == softmax_pkg::StStream);

  // Sum of the last beat lands two cycles after it, we are already in Divide then
  assign div_start_o = (state_q == softmax_pkg::StDivide) && acc_done_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      softmax_pkg::StIdle: begin
        if (start_i) begin
          state_d = softmax_pkg::StAccum;
        end
      end
      softmax_pkg::StAccum: begin
        if (acc_en_o && last_beat_i) begin
          state_d = softmax_pkg::StDivide;
        end
      end
      softmax_pkg::StDivide: begin
        if (div_done_i) begin
          state_d = softmax_pkg::StStream;
        end
      end
      softmax_pkg::StStream: begin
        if (stream_en_o && last_beat_i) begin
          state_d = softmax_pkg::StIdle;
        end
      end
      default: begin
        state_d = softmax_pkg::StIdle;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= softmax_pkg::StIdle;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

/* logic/softmax_pkg.sv */
// Row constants and types for the integer softmax unit
// Rows are fixed at RowLen scores. Scores are signed 8-bit and probabilities read 128 for 1.0
package softmax_pkg;

  localparam int NumLanes       = 4;
  localparam int RowLen         = 16;
  localparam int BeatsPerRow    = RowLen / NumLanes;
  localparam int RecipNumerator = 1 << 15;
  localparam int DivIters       = 16;

  typedef logic signed [7:0]              score_t;
  typedef logic [NumLanes*8-1:0]          score_beat_t;
  typedef logic [3:0]                     shift_t;
  typedef logic [15:0]                    sum_t;
  typedef logic [15:0]                    recip_t;
  typedef logic [7:0]                     prob_t;
  typedef logic [NumLanes*8-1:0]          prob_beat_t;
  typedef logic [$clog2(BeatsPerRow)-1:0] beat_idx_t;
  typedef logic [4:0]                     seq_len_t;

  typedef enum logic [1:0] {
    StIdle,
    StAccum,
    StDivide,
    StStream
  } ctrl_state_e;

  // Base-2 exponent shift: diff/32, rounded up when bit 4 is set
  function automatic shift_t exp_shift(input logic [7:0] diff);
    logic [4:0] sh;
    sh = {2'b00, diff[7:5]} + {4'b0000, diff[4]};
    return (sh > 5'd15) ? 4'hF : sh[3:0];
  endfunction

endpackage
